//--- hdl/timer_pkg.sv
/*
 * Shared widths, register map and types for the APB event timer unit.
 * Compile first; every other design file refers here by scoped names.
 */

package timer_pkg;

    // ****************************************
    // Sizes
    // ****************************************
    localparam int TIMER_NUM_CHANNELS = 4;
    localparam int TIMER_CNT_WIDTH    = 32;
    localparam int CHAN_IDX_WIDTH     = $clog2(TIMER_NUM_CHANNELS);

    localparam int APB_ADDR_WIDTH = 12;
    localparam int APB_DATA_WIDTH = 32;

    // Compare target after reset
    localparam logic [TIMER_CNT_WIDTH-1:0] TIMER_TARGET_RESET = 32'h1000_0000;

    // ****************************************
    // Register map
    // ****************************************
    // Word index is taken from these address bits
    localparam int WORD_IDX_MSB = 9;
    localparam int WORD_IDX_LSB = 2;

    // Low nibble of the word index selects the register
    localparam logic [3:0] REG_START  = 4'h0;
    localparam logic [3:0] REG_STOP   = 4'h1;
    localparam logic [3:0] REG_CLEAR  = 4'h2;
    localparam logic [3:0] REG_TARGET = 4'h3;

    // High nibble is channel number plus this base
    localparam logic [3:0] CHAN_BASE_NIBBLE = 4'h1;

    // ****************************************
    // Types
    // ****************************************
    typedef logic [TIMER_CNT_WIDTH-1:0] timer_cnt_t;
    typedef logic [CHAN_IDX_WIDTH-1:0]  chan_idx_t;

    typedef enum logic [1:0] {
        IDLE,
        RESP_READ,
        RESP_WRITE
    } apb_state_e;

endpackage

//--- hdl/timer_chan_if.sv
/*
 * Link between the APB register block and one timer channel.
 * One instance per channel; the register block uses the regs side.
 */

`timescale 1ns/1ps

interface timer_chan_if;

    // Single-cycle command pulses from the decoder
    logic start;
    logic stop;
    logic clear;

    // Registered compare value
    timer_pkg::timer_cnt_t target;

    // Current counter value, returned on reads
    timer_pkg::timer_cnt_t count;

    // Decoder side
    modport regs (
        output start,
        output stop,
        output clear,
        output target,
        input  count
    );

    // Channel side
    modport chan (
        input  start,
        input  stop,
        input  clear,
        input  target,
        output count
    );

endinterface

//--- hdl/event_timer.sv
/*
 * One event timer channel: run flag, 32-bit counter and compare.
 * The event is high while the count equals the target.
 */

`timescale 1ns/1ps

module event_timer (
    input  logic       clk_i,
    input  logic       rst_ni,

    // Commands and target in, count out
    timer_chan_if.chan chan,

    output logic       event_o
);

    logic                  run_q;
    logic                  match;
    timer_pkg::timer_cnt_t count_q;

    assign match = (count_q == chan.target);

    // ****************************************
    // Run flag
    // ****************************************
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            run_q <= 1'b0;
        end
        else if (chan.start)
        begin
            // Start wins over a simultaneous stop
            run_q <= 1'b1;
        end
        else if (chan.stop)
        begin
            run_q <= 1'b0;
        end
    end

    // ****************************************
    // Counter with wrap on match
    // ****************************************
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            count_q <= '0;
        end
        else if (chan.clear || match)
        begin
            count_q <= '0;
        end
        else if (run_q)
        begin
            count_q <= count_q + 1'b1;
        end
    end

    assign chan.count = count_q;
    assign event_o    = match;

endmodule

//--- hdl/apb_timer_regs.sv
/*
 * APB slave front end of the timer unit with one fixed wait state.
 * Decodes the word index into channel and register, holds the compare
 * targets and pulses start, stop and clear toward the channels.
 */

`timescale 1ns/1ps

module apb_timer_regs (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    // APB slave
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [timer_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [timer_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
    output logic [timer_pkg::APB_DATA_WIDTH-1:0] prdata_o,
    output logic                                pready_o,

    // Per-channel links
    timer_chan_if.regs                          chan [timer_pkg::TIMER_NUM_CHANNELS-1:0]
);

    localparam int NCH = timer_pkg::TIMER_NUM_CHANNELS;

    timer_pkg::apb_state_e state_q;
    timer_pkg::apb_state_e state_d;

    // Channel whose count is returned in RESP_READ
    timer_pkg::chan_idx_t rd_sel_q;
    timer_pkg::chan_idx_t rd_sel_d;

    logic [7:0]           word_idx;
    logic [3:0]           chan_num;
    logic [3:0]           addr_reg;
    logic                 chan_ok;
    timer_pkg::chan_idx_t addr_chan;

    logic [NCH-1:0]       start_pulse;
    logic [NCH-1:0]       stop_pulse;
    logic [NCH-1:0]       clear_pulse;
    logic [NCH-1:0]       target_we;

    timer_pkg::timer_cnt_t target_q  [NCH];
    timer_pkg::timer_cnt_t count_vec [NCH];

    // ****************************************
    // Address decode
    // ****************************************
    assign word_idx  = paddr_i[timer_pkg::WORD_IDX_MSB:timer_pkg::WORD_IDX_LSB];
    assign chan_num  = word_idx[7:4] - timer_pkg::CHAN_BASE_NIBBLE;
    assign addr_reg  = word_idx[3:0];
    assign addr_chan = chan_num[timer_pkg::CHAN_IDX_WIDTH-1:0];

    // High nibble must land inside the channel window
    assign chan_ok = (word_idx[7:4] >= timer_pkg::CHAN_BASE_NIBBLE) &&
                     (chan_num < 4'(NCH));

    // ****************************************
    // Access FSM
    // ****************************************
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q  <= timer_pkg::IDLE;
            rd_sel_q <= '0;
        end
        else
        begin
            state_q  <= state_d;
            rd_sel_q <= rd_sel_d;
        end
    end

    always_comb
    begin
        state_d     = timer_pkg::IDLE;
        rd_sel_d    = rd_sel_q;
        start_pulse = '0;
        stop_pulse  = '0;
        clear_pulse = '0;
        target_we   = '0;
        prdata_o    = '0;
        pready_o    = 1'b0;

        case (state_q)
            timer_pkg::IDLE:
            begin
                if (psel_i && penable_i)
                begin
                    if (!chan_ok)
                    begin
                        // Unmapped address answers at once with no side effect
                        pready_o = 1'b1;
                    end
                    else
                    begin
                        case (addr_reg)
                            timer_pkg::REG_START:
                            begin
                                start_pulse[addr_chan] = 1'b1;
                                state_d = timer_pkg::RESP_WRITE;
                            end
                            timer_pkg::REG_STOP:
                            begin
                                stop_pulse[addr_chan] = 1'b1;
                                state_d = timer_pkg::RESP_WRITE;
                            end
                            timer_pkg::REG_CLEAR:
                            begin
                                clear_pulse[addr_chan] = 1'b1;
                                state_d = timer_pkg::RESP_WRITE;
                            end
                            timer_pkg::REG_TARGET:
                            begin
                                // Writes load the target, reads see the count
                                target_we[addr_chan] = pwrite_i;
                                rd_sel_d = addr_chan;
                                state_d = timer_pkg::RESP_READ;
                            end
                            default:
                            begin
                                pready_o = 1'b1;
                            end
                        endcase
                    end
                end
            end

            timer_pkg::RESP_READ:
            begin
                prdata_o = count_vec[rd_sel_q];
                pready_o = 1'b1;
            end

            timer_pkg::RESP_WRITE:
            begin
                pready_o = 1'b1;
            end

            default:
            begin
                state_d = timer_pkg::IDLE;
            end
        endcase
    end

    // ****************************************
    // Targets and channel wiring
    // ****************************************
    for (genvar g = 0; g < NCH; g++)
    begin : g_chan
        always_ff @(posedge clk_i or negedge rst_ni)
        begin
            if (!rst_ni)
            begin
                target_q[g] <= timer_pkg::TIMER_TARGET_RESET;
            end
            else if (target_we[g])
            begin
                target_q[g] <= pwdata_i;
            end
        end

        assign chan[g].start  = start_pulse[g];
        assign chan[g].stop   = stop_pulse[g];
        assign chan[g].clear  = clear_pulse[g];
        assign chan[g].target = target_q[g];
        assign count_vec[g]   = chan[g].count;
    end

endmodule

//--- hdl/timer_unit_top.sv
/*
 * Top level of the APB event timer unit.
 * Plain APB slave and event ports; connect the APB master and route
 * event_o to the event sinks.
 */

`timescale 1ns/1ps

module timer_unit_top (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,

    // ****************************************
    // APB slave
    // ****************************************
    input  logic                                    psel_i,
    input  logic                                    penable_i,
    input  logic                                    pwrite_i,
    input  logic [timer_pkg::APB_ADDR_WIDTH-1:0]     paddr_i,
    input  logic [timer_pkg::APB_DATA_WIDTH-1:0]     pwdata_i,
    output logic [timer_pkg::APB_DATA_WIDTH-1:0]     prdata_o,
    output logic                                    pready_o,

    // ****************************************
    // Events, one bit per channel
    // ****************************************
    output logic [timer_pkg::TIMER_NUM_CHANNELS-1:0] event_o
);

    // One link per channel
    timer_chan_if chan_if [timer_pkg::TIMER_NUM_CHANNELS-1:0] ();

    // Bus decode, targets and command pulses
    apb_timer_regs apb_timer_regs_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .chan      (chan_if)
    );

    // Identical counter channels
    for (genvar g = 0; g < timer_pkg::TIMER_NUM_CHANNELS; g++)
    begin : g_timer
        event_timer event_timer_inst (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .chan    (chan_if[g]),
            .event_o (event_o[g])
        );
    end

endmodule

//--- test/tb_timer_unit.sv
/*
 * Testbench for the APB event timer unit.
 * Drives APB reads and writes, watches event_o and queues observations
 * for a checker process; run through sources.f with the top tb_timer_unit.
 */

`timescale 1ns/1ps

module tb_timer_unit;

    localparam int CLK_PERIOD_NS = 8;
    localparam int RAND_SEED     = 72254;
    localparam int EVENT_EDGES   = 4;

    // Cycle budgets per test, summed for the watchdog
    localparam int BUDGET_RESET   = 40;
    localparam int BUDGET_UNMAP   = 60;
    localparam int BUDGET_HOLD    = 200;
    localparam int BUDGET_CLEAR   = 60;
    localparam int BUDGET_PERIOD  = 300;
    localparam int BUDGET_INDEP   = 200;
    localparam int BUDGET_MARGIN  = 200;
    localparam int WATCHDOG_NS    = CLK_PERIOD_NS * (BUDGET_RESET + BUDGET_UNMAP +
        BUDGET_HOLD + BUDGET_CLEAR + BUDGET_PERIOD + BUDGET_INDEP + BUDGET_MARGIN);

    logic                                     clk_i;
    logic                                     rst_ni;
    logic                                     psel_i;
    logic                                     penable_i;
    logic                                     pwrite_i;
    logic [timer_pkg::APB_ADDR_WIDTH-1:0]     paddr_i;
    logic [timer_pkg::APB_DATA_WIDTH-1:0]     pwdata_i;
    logic [timer_pkg::APB_DATA_WIDTH-1:0]     prdata_o;
    logic                                     pready_o;
    logic [timer_pkg::TIMER_NUM_CHANNELS-1:0] event_o;

    // Observation queues shared with the checker
    string       name_q [$];
    logic [31:0] exp_q  [$];
    logic [31:0] act_q  [$];
    bit          end_q  [$];

    string       cur_test;
    string       item_name;
    logic [31:0] item_exp;
    logic [31:0] item_act;
    bit          item_end;
    int          test_errs;
    int          total_errs;
    int          checks_done;
    int          tests_passed;
    int          tests_failed;

    timer_unit_top timer_unit_top_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .event_o   (event_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
    end

    // ****************************************
    // Reference functions
    // ****************************************
    // Channel, offset and mapped flag of an APB address
    function automatic bit expected_addr_decode(input logic [11:0] addr,
                                                output int ch, output int offs);
        logic [7:0] word;
        bit         reg_ok;
        word   = addr[timer_pkg::WORD_IDX_MSB:timer_pkg::WORD_IDX_LSB];
        ch     = int'(word[7:4]) - int'(timer_pkg::CHAN_BASE_NIBBLE);
        offs   = int'(word[3:0]);
        reg_ok = (word[3:0] == timer_pkg::REG_START) || (word[3:0] == timer_pkg::REG_STOP) ||
                 (word[3:0] == timer_pkg::REG_CLEAR) || (word[3:0] == timer_pkg::REG_TARGET);
        return (ch >= 0) && (ch < timer_pkg::TIMER_NUM_CHANNELS) && reg_ok;
    endfunction

    function automatic int expected_event_period(input int target);
        return target + 1;
    endfunction

    function automatic logic [11:0] word_addr(input logic [7:0] word);
        logic [11:0] addr;
        addr = '0;
        addr[timer_pkg::WORD_IDX_MSB:timer_pkg::WORD_IDX_LSB] = word;
        return addr;
    endfunction

    function automatic logic [11:0] reg_addr(input int ch, input logic [3:0] offs);
        return word_addr({4'(ch) + timer_pkg::CHAN_BASE_NIBBLE, offs});
    endfunction

    function automatic int pick_between(input int lo, input int hi);
        return lo + int'($urandom % unsigned'(hi - lo + 1));
    endfunction

    // ****************************************
    // Observation and APB tasks
    // ****************************************
    task automatic expect_value(input string what, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        name_q.push_back({cur_test, " ", what});
        exp_q.push_back(exp_v);
        act_q.push_back(act_v);
        end_q.push_back(1'b0);
    endtask

    task automatic end_test();
        name_q.push_back(cur_test);
        exp_q.push_back('0);
        act_q.push_back('0);
        end_q.push_back(1'b1);
    endtask

    // Setup phase, then access phase held until pready_o
    task automatic apb_transfer(input bit wr, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int waits;
        int ch;
        int offs;
        bit mapped;
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk_i);
        penable_i <= 1'b1;
        waits = 0;
        @(negedge clk_i);
        while (!pready_o)
        begin
            waits++;
            @(negedge clk_i);
        end
        rdata = prdata_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        mapped = expected_addr_decode(addr, ch, offs);
        // Mapped registers add one wait state
        expect_value("pready wait", mapped ? 1 : 0, waits);
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
        logic [31:0] unused_rdata;
        apb_transfer(1'b1, addr, wdata, unused_rdata);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata);
        apb_transfer(1'b0, addr, '0, rdata);
    endtask

    // ****************************************
    // Tests
    // ****************************************
    task automatic test_reset_state();
        logic [31:0] data;
        cur_test = "reset_state";
        @(negedge clk_i);
        expect_value("event_o", '0, 32'(event_o));
        for (int ch = 0; ch < timer_pkg::TIMER_NUM_CHANNELS; ch++)
        begin
            apb_read(reg_addr(ch, timer_pkg::REG_TARGET), data);
            expect_value($sformatf("count ch%0d", ch), '0, data);
        end
        end_test();
    endtask

    task automatic test_unmapped();
        logic [31:0] data;
        logic [7:0]  bad_words [3];
        cur_test = "unmapped";
        bad_words = '{8'h05, 8'h50, 8'h14};
        foreach (bad_words[i])
        begin
            apb_read(word_addr(bad_words[i]), data);
            expect_value($sformatf("prdata word 0x%02h", bad_words[i]), '0, data);
        end
        for (int ch = 0; ch < timer_pkg::TIMER_NUM_CHANNELS; ch++)
        begin
            apb_read(reg_addr(ch, timer_pkg::REG_TARGET), data);
            expect_value($sformatf("count ch%0d", ch), '0, data);
        end
        end_test();
    endtask

    task automatic test_start_stop_hold(output int ch);
        logic [31:0] v1;
        logic [31:0] v2;
        cur_test = "start_stop_hold";
        ch = pick_between(0, timer_pkg::TIMER_NUM_CHANNELS - 1);
        apb_write(reg_addr(ch, timer_pkg::REG_START), '0);
        repeat (pick_between(5, 60)) @(posedge clk_i);
        apb_write(reg_addr(ch, timer_pkg::REG_STOP), '0);
        apb_read(reg_addr(ch, timer_pkg::REG_TARGET), v1);
        repeat (pick_between(1, 40)) @(posedge clk_i);
        apb_read(reg_addr(ch, timer_pkg::REG_TARGET), v2);
        expect_value("held count", v1, v2);
        expect_value("count nonzero", 1, 32'(v1 != 0));
        expect_value("below reset target", 1, 32'(v1 < timer_pkg::TIMER_TARGET_RESET));
        end_test();
    endtask

    task automatic test_clear(input int ch);
        logic [31:0] data;
        cur_test = "clear";
        apb_write(reg_addr(ch, timer_pkg::REG_CLEAR), '0);
        apb_read(reg_addr(ch, timer_pkg::REG_TARGET), data);
        expect_value("count after clear", '0, data);
        repeat (pick_between(5, 20)) @(posedge clk_i);
        apb_read(reg_addr(ch, timer_pkg::REG_TARGET), data);
        expect_value("still stopped", '0, data);
        end_test();
    endtask

    task automatic test_event_period();
        int ch;
        int t;
        int edges;
        int high_len;
        int last_rise;
        int cyc;
        int hits;
        bit ev;
        bit prev_ev;
        cur_test = "event_period";
        ch = pick_between(0, timer_pkg::TIMER_NUM_CHANNELS - 1);
        t  = pick_between(3, 20);
        apb_write(reg_addr(ch, timer_pkg::REG_TARGET), 32'(t));
        apb_write(reg_addr(ch, timer_pkg::REG_CLEAR), '0);
        apb_write(reg_addr(ch, timer_pkg::REG_START), '0);
        edges     = 0;
        high_len  = 0;
        last_rise = 0;
        cyc       = 0;
        @(negedge clk_i);
        prev_ev   = event_o[ch];
        while (edges < EVENT_EDGES && cyc < (EVENT_EDGES + 1) * (t + 1) + 10)
        begin
            @(negedge clk_i);
            cyc++;
            ev = event_o[ch];
            if (ev && !prev_ev)
            begin
                if (edges > 0)
                begin
                    expect_value("event spacing", expected_event_period(t), cyc - last_rise);
                end
                last_rise = cyc;
                edges++;
                high_len = 1;
            end
            else if (ev)
            begin
                high_len++;
            end
            else if (prev_ev)
            begin
                expect_value("event width", 1, high_len);
            end
            prev_ev = ev;
        end
        expect_value("event count", EVENT_EDGES, edges);
        @(negedge clk_i);
        expect_value("event low after pulse", 0, 32'(event_o[ch]));

        // A stop right at the match may still give one last pulse
        apb_write(reg_addr(ch, timer_pkg::REG_STOP), '0);
        repeat (2) @(negedge clk_i);
        hits = 0;
        repeat (3 * expected_event_period(t))
        begin
            @(negedge clk_i);
            if (event_o[ch])
            begin
                hits++;
            end
        end
        expect_value("events after stop", 0, hits);
        end_test();
    endtask

    task automatic test_independence();
        int          run_ch;
        int          t;
        int          other_hits;
        int          pulses;
        bit          prev_ev;
        logic [31:0] data;
        logic [timer_pkg::TIMER_NUM_CHANNELS-1:0] others;
        cur_test = "independence";
        for (int ch = 0; ch < timer_pkg::TIMER_NUM_CHANNELS; ch++)
        begin
            apb_write(reg_addr(ch, timer_pkg::REG_CLEAR), '0);
        end
        run_ch = pick_between(0, timer_pkg::TIMER_NUM_CHANNELS - 1);
        t      = pick_between(3, 8);
        apb_write(reg_addr(run_ch, timer_pkg::REG_TARGET), 32'(t));
        apb_write(reg_addr(run_ch, timer_pkg::REG_START), '0);
        other_hits = 0;
        pulses     = 0;
        @(negedge clk_i);
        prev_ev    = event_o[run_ch];
        repeat (4 * expected_event_period(t))
        begin
            @(negedge clk_i);
            others = event_o;
            others[run_ch] = 1'b0;
            if (others != '0)
            begin
                other_hits++;
            end
            if (event_o[run_ch] && !prev_ev)
            begin
                pulses++;
            end
            prev_ev = event_o[run_ch];
        end
        expect_value("other events", 0, other_hits);
        expect_value("running channel pulses", 1, 32'(pulses >= 3));
        for (int ch = 0; ch < timer_pkg::TIMER_NUM_CHANNELS; ch++)
        begin
            if (ch != run_ch)
            begin
                apb_read(reg_addr(ch, timer_pkg::REG_TARGET), data);
                expect_value($sformatf("idle count ch%0d", ch), '0, data);
            end
        end
        apb_write(reg_addr(run_ch, timer_pkg::REG_STOP), '0);
        end_test();
    endtask

    // ****************************************
    // Checker
    // ****************************************
    always @(negedge clk_i)
    begin
        while (end_q.size() > 0)
        begin
            item_end  = end_q.pop_front();
            item_name = name_q.pop_front();
            item_exp  = exp_q.pop_front();
            item_act  = act_q.pop_front();
            if (item_end)
            begin
                if (test_errs == 0)
                begin
                    $display("[pass] %s", item_name);
                    tests_passed++;
                end
                else
                begin
                    $display("[fail] %s, %0d errors", item_name, test_errs);
                    tests_failed++;
                end
                test_errs = 0;
            end
            else
            begin
                checks_done++;
                if (item_act !== item_exp)
                begin
                    $display("error %s: expected 0x%08h, actual 0x%08h",
                             item_name, item_exp, item_act);
                    test_errs++;
                    total_errs++;
                end
            end
        end
    end

    // Watchdog sized from the per-test budgets
    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        int hold_ch;
        void'($urandom(RAND_SEED));
        test_errs    = 0;
        total_errs   = 0;
        checks_done  = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst_ni       = 1'b0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        paddr_i      = '0;
        pwdata_i     = '0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;

        test_reset_state();
        test_unmapped();
        test_start_stop_hold(hold_ch);
        test_clear(hold_ch);
        test_event_period();
        test_independence();

        // Let the checker drain the queue
        repeat (2) @(negedge clk_i);
        $display("tests passed: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_passed, tests_failed, checks_done, total_errs);
        if (tests_failed == 0 && total_errs == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
hdl/timer_pkg.sv
hdl/timer_chan_if.sv
hdl/event_timer.sv
hdl/apb_timer_regs.sv
hdl/timer_unit_top.sv
test/tb_timer_unit.sv

//--- run.sh
#!/bin/sh
# Build the timer unit testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_timer_unit -f sources.f \
    && ./obj_dir/Vtb_timer_unit > sim.log 2>&1 \
    || { echo "build or simulation run error"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation reported failures"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation log has no result line"; exit 1; }
exit 0
